//--- l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

    ////////////////////
    // address fields
    ////////////////////

    localparam int ADDR_W    = 27;  // cpu word address
    localparam int OFF_W     = 2;   // word in line, 4 words
    localparam int SET_W_DEF = 12;  // index bits, 4096 sets
    localparam int WORD_W    = 32;
    localparam int LINE_W    = 128;

    // whatever is left above index and offset
    localparam int TAG_W   = ADDR_W - OFF_W - SET_W_DEF;
    localparam int LADDR_W = ADDR_W - OFF_W;  // line address toward memory

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // directory entry, one per set per way
    typedef struct packed {
        logic             valid;
        logic             dirty;  // line differs from memory
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    ////////////////////
    // cpu side
    ////////////////////

    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // word address
        word_t             data;   // write data
        logic              rw;     // 1 = write
        logic              valid;  // held until ready
    } cpu_req_t;

    typedef struct packed {
        word_t data;
        logic  ready;  // one cycle pulse
    } cpu_res_t;

    ////////////////////
    // memory side
    ////////////////////

    typedef struct packed {
        logic [LADDR_W-1:0] addr;   // line address, no offset
        line_t              data;   // write-back line
        logic               rw;     // 1 = write-back pulse
        logic               valid;
    } mem_req_t;

    typedef struct packed {
        line_t data;
        logic  ready;  // fill data valid, one cycle
    } mem_resp_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        compare_tag,
        allocate,
        allocate_wait,
        write_back
    } cache_state_t;

endpackage

`default_nettype wire

//--- way_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single port ram, read-first
// serves as tag directory or line store depending on entry_t
module way_ram
    import l1_cache_pkg::*;
#(
    parameter int  DEPTH_W = SET_W_DEF,  // address bits
    parameter type entry_t = line_t      // stored payload
)
(
    input  wire logic               CLK,
    input  wire logic [DEPTH_W-1:0] addr,  // set index
    input  wire logic               we,
    input  wire entry_t             din,
    output entry_t                  dout   // registered, one cycle after addr
);

    entry_t mem [2**DEPTH_W];  // one entry per set

    // power-up contents are all zero, so valid bits start clear
    initial
    begin
        for (int i = 0; i < 2**DEPTH_W; i++)
        begin
            mem[i] = '0;
        end
        dout = '0;
    end

    ////////////////////
    // port
    ////////////////////

    always @(posedge CLK)
    begin
        if (we)
        begin
            mem[addr] <= din;  // new value visible on the next read
        end
        dout <= mem[addr];     // old value on a write cycle
    end

endmodule

`default_nettype wire

//--- way_compare.sv
`timescale 1ns/1ps
`default_nettype none

// one per way
// tag match, word pick for reads, lane merge for writes
module way_compare
    import l1_cache_pkg::*;
(
    input  wire tag_entry_t tag_q,    // directory entry for current set
    input  wire line_t      line_q,   // stored line for current set
    input  wire cpu_req_t   cpu_req,
    output logic            hit,
    output word_t           rd_word,  // addressed word of line_q
    output line_t           wr_line   // line_q with write data merged in
);

    logic [TAG_W-1:0] req_tag;
    logic [OFF_W-1:0] offset;

    ////////////////////
    // address split
    ////////////////////

    assign req_tag = cpu_req.addr[ADDR_W-1 -: TAG_W];  // top bits
    assign offset  = cpu_req.addr[OFF_W-1:0];          // word lane

    // stale tags of invalid lines never count
    assign hit = tag_q.valid && (tag_q.tag == req_tag);

    ////////////////////
    // data lanes
    ////////////////////

    // lane 0 sits at the low end of the line
    assign rd_word = line_q[offset*WORD_W +: WORD_W];

    always_comb
    begin
        wr_line = line_q;                               // keep other lanes
        wr_line[offset*WORD_W +: WORD_W] = cpu_req.data;  // replace one
    end

endmodule

`default_nettype wire

//--- set_lru.sv
`timescale 1ns/1ps
`default_nettype none

// one replacement bit per set
// the bit names the way to evict next
module set_lru
    import l1_cache_pkg::*;
#(
    parameter int SET_W = SET_W_DEF
)
(
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic [SET_W-1:0] index,        // current set
    input  wire logic             touch,        // hit this cycle
    input  wire logic             touched_way,  // way that hit
    output logic                  victim        // way to replace
);

    logic [2**SET_W-1:0] lru_q;  // 0 = evict way0

    ////////////////////
    // state
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            lru_q <= '0;  // all sets start on way0
        end
        else if (touch)
        begin
            lru_q[index] <= ~touched_way;  // other way is now older
        end
    end

    assign victim = lru_q[index];

    // touch only comes from a hit in compare_tag, which is always
    // followed by idle, so it can never repeat on the next cycle
    touch_once_a: assert property (@(posedge CLK) disable iff (RST)
        touch |=> !touch);

endmodule

`default_nettype wire

//--- cache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// cache controller
// hit return, write merge, victim write-back, line fill, replay
module cache_fsm
    import l1_cache_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       RST,
    input  wire cpu_req_t   cpu_req,
    input  wire logic       hit0,
    input  wire logic       hit1,
    input  wire word_t      rd_word0,
    input  wire word_t      rd_word1,
    input  wire line_t      wr_line0,   // merged lines from the comparators
    input  wire line_t      wr_line1,
    input  wire tag_entry_t tag_q0,
    input  wire tag_entry_t tag_q1,
    input  wire line_t      line_q0,    // raw lines, for write-back
    input  wire line_t      line_q1,
    input  wire logic       victim,     // from lru
    input  wire mem_resp_t  mem_resp,
    output cpu_res_t        cpu_res,
    output mem_req_t        mem_req,
    output logic            tag_we0,
    output logic            tag_we1,
    output tag_entry_t      tag_din,    // shared by both directories
    output logic            line_we0,
    output logic            line_we1,
    output line_t           line_din0,
    output line_t           line_din1,
    output logic            touch,
    output logic            touched_way
);

    cache_state_t       state_q;
    cache_state_t       state_d;
    logic               victim_q;  // way being refilled
    logic               any_hit;
    tag_entry_t         vic_tag;
    line_t              vic_line;
    logic [TAG_W-1:0]   req_tag;
    logic [LADDR_W-1:0] req_line;

    assign any_hit  = hit0 | hit1;
    assign vic_tag  = victim ? tag_q1 : tag_q0;    // live victim, compare_tag only
    assign vic_line = victim ? line_q1 : line_q0;
    assign req_tag  = cpu_req.addr[ADDR_W-1 -: TAG_W];
    assign req_line = cpu_req.addr[ADDR_W-1:OFF_W];  // offset dropped

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state_q  <= idle;
            victim_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == compare_tag && !any_hit)
            begin
                victim_q <= victim;  // hold for the fill write
            end
        end
    end

    ////////////////////
    // next state, outputs
    ////////////////////

    always_comb
    begin
        state_d       = state_q;
        cpu_res.data  = hit1 ? rd_word1 : rd_word0;
        cpu_res.ready = 1'b0;
        mem_req.addr  = req_line;
        mem_req.data  = '0;
        mem_req.rw    = 1'b0;
        mem_req.valid = 1'b0;
        tag_we0       = 1'b0;
        tag_we1       = 1'b0;
        tag_din.valid = 1'b1;     // new or rewritten entry
        tag_din.dirty = 1'b0;
        tag_din.tag   = req_tag;  // same as stored tag on a hit
        line_we0      = 1'b0;
        line_we1      = 1'b0;
        line_din0     = wr_line0;
        line_din1     = wr_line1;
        touch         = 1'b0;
        touched_way   = hit1;

        case (state_q)
            idle:
            begin
                if (cpu_req.valid)
                begin
                    state_d = compare_tag;  // ram read in flight
                end
            end

            compare_tag:
            begin
                if (any_hit)
                begin
                    cpu_res.ready = 1'b1;
                    touch         = 1'b1;
                    if (cpu_req.rw)  // write hit, merge and mark dirty
                    begin
                        tag_we0       = hit0;
                        tag_we1       = hit1;
                        tag_din.dirty = 1'b1;
                        line_we0      = hit0;
                        line_we1      = hit1;
                    end
                    state_d = idle;
                end
                else
                begin
                    tag_we0 = ~victim;  // claim victim with the new tag
                    tag_we1 = victim;
                    if (vic_tag.valid && vic_tag.dirty)
                    begin
                        // old line goes out as a single pulse
                        mem_req.addr  = {vic_tag.tag, cpu_req.addr[ADDR_W-TAG_W-1:OFF_W]};
                        mem_req.data  = vic_line;
                        mem_req.rw    = 1'b1;
                        mem_req.valid = 1'b1;
                        state_d       = write_back;
                    end
                    else
                    begin
                        state_d = allocate;  // clean or empty victim
                    end
                end
            end

            write_back:
            begin
                state_d = allocate;  // gap after the pulse
            end

            allocate:
            begin
                mem_req.valid = 1'b1;  // read held until ready
                line_din0     = mem_resp.data;
                line_din1     = mem_resp.data;
                if (mem_resp.ready)
                begin
                    line_we0 = ~victim_q;
                    line_we1 = victim_q;
                    state_d  = allocate_wait;
                end
            end

            allocate_wait:
            begin
                state_d = compare_tag;  // reread set, replay as a hit
            end

            default:
            begin
                state_d = idle;
            end
        endcase
    end

    // a set never holds the same tag in both ways
    one_hit_a: assert property (@(posedge CLK) disable iff (RST)
        state_q == compare_tag |-> !(hit0 && hit1));

    // write-back is a pulse, never held
    wb_pulse_a: assert property (@(posedge CLK) disable iff (RST)
        (mem_req.valid && mem_req.rw) |=> !(mem_req.valid && mem_req.rw));

endmodule

`default_nettype wire

//--- l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

// two-way set associative l1 data cache
// write-back, write-allocate
module l1_cache
    import l1_cache_pkg::*;
#(
    parameter int SET_W = SET_W_DEF  // must match the tag width in the package
)
(
    input  wire logic      CLK,
    input  wire logic      RST,
    input  wire cpu_req_t  cpu_req,
    output cpu_res_t       cpu_res,
    output mem_req_t       mem_req,
    input  wire mem_resp_t mem_resp
);

    logic [SET_W-1:0] index;
    tag_entry_t       tag_q0, tag_q1;
    tag_entry_t       tag_din;
    line_t            line_q0, line_q1;
    line_t            line_din0, line_din1;
    line_t            wr_line0, wr_line1;
    word_t            rd_word0, rd_word1;
    logic             hit0, hit1;
    logic             tag_we0, tag_we1;
    logic             line_we0, line_we1;
    logic             victim;
    logic             touch;
    logic             touched_way;

    assign index = cpu_req.addr[OFF_W +: SET_W];  // every ram, every cycle

    ////////////////////
    // directories
    ////////////////////

    way_ram #(.DEPTH_W(SET_W), .entry_t(tag_entry_t)) tag_ram0 (
        .CLK(CLK), .addr(index), .we(tag_we0), .din(tag_din), .dout(tag_q0)
    );

    way_ram #(.DEPTH_W(SET_W), .entry_t(tag_entry_t)) tag_ram1 (
        .CLK(CLK), .addr(index), .we(tag_we1), .din(tag_din), .dout(tag_q1)
    );

    ////////////////////
    // line stores
    ////////////////////

    way_ram #(.DEPTH_W(SET_W), .entry_t(line_t)) line_ram0 (
        .CLK(CLK), .addr(index), .we(line_we0), .din(line_din0), .dout(line_q0)
    );

    way_ram #(.DEPTH_W(SET_W), .entry_t(line_t)) line_ram1 (
        .CLK(CLK), .addr(index), .we(line_we1), .din(line_din1), .dout(line_q1)
    );

    // per way match and data path
    way_compare cmp0 (
        .tag_q(tag_q0), .line_q(line_q0), .cpu_req(cpu_req),
        .hit(hit0), .rd_word(rd_word0), .wr_line(wr_line0)
    );

    way_compare cmp1 (
        .tag_q(tag_q1), .line_q(line_q1), .cpu_req(cpu_req),
        .hit(hit1), .rd_word(rd_word1), .wr_line(wr_line1)
    );

    set_lru #(.SET_W(SET_W)) lru_i (
        .CLK(CLK), .RST(RST), .index(index),
        .touch(touch), .touched_way(touched_way), .victim(victim)
    );

    cache_fsm fsm_i (
        .CLK(CLK), .RST(RST), .cpu_req(cpu_req),
        .hit0(hit0), .hit1(hit1),
        .rd_word0(rd_word0), .rd_word1(rd_word1),
        .wr_line0(wr_line0), .wr_line1(wr_line1),
        .tag_q0(tag_q0), .tag_q1(tag_q1),
        .line_q0(line_q0), .line_q1(line_q1),
        .victim(victim), .mem_resp(mem_resp),
        .cpu_res(cpu_res), .mem_req(mem_req),
        .tag_we0(tag_we0), .tag_we1(tag_we1), .tag_din(tag_din),
        .line_we0(line_we0), .line_we1(line_we1),
        .line_din0(line_din0), .line_din1(line_din1),
        .touch(touch), .touched_way(touched_way)
    );

endmodule

`default_nettype wire

//--- tb_l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int CLK_P     = 4;  // ns
    localparam int HIT_EDGES = 2;  // edge taking valid, edge taking ready

    logic      CLK;
    logic      RST;
    cpu_req_t  cpu_req;
    cpu_res_t  cpu_res;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    // test file contents, one entry per operation
    logic [7:0]        t_op[$];    // R, W or E
    logic [ADDR_W-1:0] t_addr[$];
    word_t             t_data[$];
    logic [7:0]        t_kind[$];  // H or M
    int                n_lines;
    logic              loaded;

    ////////////////////
    // lower memory state
    ////////////////////

    word_t    mem_q[logic [ADDR_W-1:0]];  // written words only
    int       seed;
    logic     rd_busy;
    int       rd_wait;      // cycles left on the current fill
    int       read_count;
    int       wb_count;
    mem_req_t rd_seen;      // last fill request
    mem_req_t wb_exp;       // line due on the next write-back
    logic     wb_pending;

    l1_cache #(.SET_W(SET_W_DEF)) dut_i (
        .CLK(CLK), .RST(RST), .cpu_req(cpu_req), .cpu_res(cpu_res),
        .mem_req(mem_req), .mem_resp(mem_resp)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #(CLK_P / 2) CLK = ~CLK;
        end
    end

    ////////////////////
    // reporting
    ////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act.addr !== exp.addr || act.data !== exp.data)
        begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %h/%h, got %h/%h",
                $time, name, exp.addr, exp.data, act.addr, act.data));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %0d, got %0d",
                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                $time, name, exp, act));
        end
    endtask

    ////////////////////
    // memory model
    ////////////////////

    // untouched words follow the address pattern
    function automatic word_t mem_word(input logic [ADDR_W-1:0] waddr);
        if (mem_q.exists(waddr))
        begin
            return mem_q[waddr];
        end
        return word_t'(waddr) ^ 32'h5A5A0000;
    endfunction

    task automatic answer_read();
        for (int w = 0; w < 2**OFF_W; w++)
        begin
            mem_resp.data[w*WORD_W +: WORD_W] = mem_word({mem_req.addr, OFF_W'(w)});
        end
        mem_resp.ready = 1'b1;
    endtask

    task automatic take_write_back();
        wb_count = wb_count + 1;
        if (!wb_pending)
        begin
            stop_run($sformatf("write-back to line %h that no test line expects", mem_req.addr));
        end
        else
        begin
            check_mem_req("mem_req write-back", wb_exp, mem_req);
            wb_pending = 1'b0;
            wb_exp     = '0;
            for (int w = 0; w < 2**OFF_W; w++)
            begin
                mem_q[{mem_req.addr, OFF_W'(w)}] = mem_req.data[w*WORD_W +: WORD_W];
            end
        end
    endtask

    always @(negedge CLK)
    begin
        if (!RST)
        begin
            if (mem_req.valid && mem_req.rw)
            begin
                take_write_back();  // single pulse, taken at once
            end
            if (mem_resp.ready)
            begin
                mem_resp.ready = 1'b0;  // fill pulse lasts one cycle
            end
            else if (mem_req.valid && !mem_req.rw)
            begin
                if (!rd_busy)
                begin
                    rd_busy    = 1'b1;
                    rd_wait    = 1 + ($unsigned($random(seed)) % 6);  // 1 to 6 cycles
                    read_count = read_count + 1;
                    rd_seen    = mem_req;
                end
                if (rd_wait > 1)
                begin
                    rd_wait = rd_wait - 1;
                end
                else
                begin
                    answer_read();
                    rd_busy = 1'b0;
                end
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic load_tests();
        int                fd;
        int                n;
        string             line;
        logic [7:0]        op;
        logic [7:0]        kind;
        logic [ADDR_W-1:0] addr;
        word_t             data;
        fd = $fopen("l1_cache_tests.txt", "r");
        if (fd == 0)
        begin
            stop_run("cannot open l1_cache_tests.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0)
                begin
                    n_lines = n_lines + 1;
                end
                n = $sscanf(line, "%c %h %h %c", op, addr, data, kind);
                if (n == 4 && (op == "R" || op == "W" || op == "E"))  // comments drop out
                begin
                    t_op.push_back(op);
                    t_addr.push_back(addr);
                    t_data.push_back(data);
                    t_kind.push_back(kind);
                end
            end
            $fclose(fd);
        end
    endtask

    // one word of the line the next request should evict
    task automatic expect_write_back(input logic [ADDR_W-1:0] waddr, input word_t w);
        wb_exp.addr  = waddr[ADDR_W-1:OFF_W];
        wb_exp.data[waddr[OFF_W-1:0]*WORD_W +: WORD_W] = w;
        wb_exp.rw    = 1'b1;
        wb_exp.valid = 1'b1;
        wb_pending   = 1'b1;
    endtask

    task automatic run_request(input int i);
        int       edges;
        int       reads_before;
        int       wbs_before;
        int       wb_due;
        word_t    got;
        mem_req_t exp_rd;
        reads_before  = read_count;
        wbs_before    = wb_count;
        wb_due        = wb_pending ? 1 : 0;
        cpu_req.addr  = t_addr[i];
        cpu_req.data  = t_data[i];
        cpu_req.rw    = (t_op[i] == "W");
        cpu_req.valid = 1'b1;
        edges         = 0;
        do
        begin
            @(negedge CLK);
            edges = edges + 1;
        end
        while (!cpu_res.ready);
        got   = cpu_res.data;
        edges = edges + 1;      // the edge that takes ready
        @(negedge CLK);         // request held through that edge
        cpu_req.valid = 1'b0;

        if (t_op[i] == "R")
        begin
            check_word("cpu_res.data", t_data[i], got);
        end
        if (t_kind[i] == "H")
        begin
            check_count("hit latency in cycles", HIT_EDGES, edges);
            check_count("fill requests", reads_before, read_count);
        end
        else
        begin
            check_count("fill requests", reads_before + 1, read_count);
            exp_rd       = '0;
            exp_rd.addr  = t_addr[i][ADDR_W-1:OFF_W];  // offset zeroed
            exp_rd.valid = 1'b1;
            check_mem_req("mem_req fill", exp_rd, rd_seen);
        end
        check_count("write-back pulses", wbs_before + wb_due, wb_count);
    endtask

    // watchdog, sized from the file length
    initial
    begin
        int limit;
        wait (loaded === 1'b1);
        limit = 40 * n_lines + 100;
        #(limit * CLK_P);
        stop_run($sformatf("timeout, the test sequence did not finish in %0d cycles", limit));
    end

    initial
    begin
        RST        = 1'b1;
        cpu_req    = '0;
        mem_resp   = '0;
        seed       = 98;
        rd_busy    = 1'b0;
        rd_wait    = 0;
        read_count = 0;
        wb_count   = 0;
        rd_seen    = '0;
        wb_exp     = '0;
        wb_pending = 1'b0;
        n_lines    = 0;
        loaded     = 1'b0;
        load_tests();
        loaded = 1'b1;

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        // quiet outputs before the first request
        repeat (3)
        begin
            @(negedge CLK);
            check_flag("cpu_res.ready", 1'b0, cpu_res.ready);
            check_flag("mem_req.valid", 1'b0, mem_req.valid);
        end

        foreach (t_op[i])
        begin
            if (t_op[i] == "E")
            begin
                expect_write_back(t_addr[i], t_data[i]);
            end
            else
            begin
                run_request(i);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- l1_cache_tests.txt
# op addr data kind: R read with expected word, W write with write data, H hit or M miss
# E addr data -: one word of the line that the next request must write back
R 0004042 5A5A4042 M
R 0004040 5A5A4040 H
R 0004041 5A5A4041 H
R 0004043 5A5A4043 H
W 0004041 DEADBEEF H
R 0004041 DEADBEEF H
R 0004040 5A5A4040 H
W 0004083 CAFEF00D M
R 0004083 CAFEF00D H
R 0004080 5A5A4080 H
R 0008040 5A5A8040 M
R 0004040 5A5A4040 H
R 000C040 5A5AC040 M
R 0004041 DEADBEEF H
R 0008040 5A5A8040 M
E 0004040 5A5A4040 -
E 0004041 DEADBEEF -
E 0004042 5A5A4042 -
E 0004043 5A5A4043 -
R 0010040 5A5B0040 M
R 0004041 DEADBEEF M
R 0004042 5A5A4042 H

//--- sources.f
l1_cache_pkg.sv
way_ram.sv
way_compare.sv
set_lru.sv
cache_fsm.sv
l1_cache.sv
tb_l1_cache.sv

//--- Makefile
# verilator build and run for the l1 cache testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SRCS      := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
